//--- icache_top.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_refill_if.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_miss_ctrl.sv
verilog/icache_top.sv
tests/icache_top_assertions.sv
tests/icache_top_tb.sv

//--- tests/icache_top_tb.sv
// instruction cache testbench
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_top_tb;

    localparam int WAIT_LIMIT = 20;

    typedef struct {
        logic [31:0] pc;
        logic        stall;
        logic        flush;
        logic [1:0]  resp;
    } stim_t;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic        flush;
    logic        stall;
    logic        arready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
    logic        rvalid;
    logic [1:0]  rresp;
    logic [63:0] rdata;
    logic        rlast;
    logic [3:0]  rid;
    logic [31:0] inst;
    logic        inst_valid;
    logic        error;

    integer seed;
    int     failures;
    stim_t  steps [$];

    // reference copy of tags, valid and victim bits
    logic [20:0] model_tag    [2][256];
    logic        model_valid  [2][256];
    logic        model_victim [256];
    logic [63:0] model_line   [2][256];
    logic        model_error;

    // instruction the outputs should hold
    logic [31:0] last_inst;
    logic        last_valid;

    icache_top i_icache_top (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .flush      (flush),
        .stall      (stall),
        .arready    (arready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .rvalid     (rvalid),
        .rresp      (rresp),
        .rdata      (rdata),
        .rlast      (rlast),
        .rid        (rid),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // failure reporting

    task automatic stop_on_failure();
        failures++;
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for the %s", what);
        stop_on_failure();
    endtask

    // ==================================================
    // bus memory model, called at a falling edge with arvalid high

    task automatic serve_read(input logic [1:0] resp, output logic [31:0] addr);
        int          ar_delay;
        int          r_delay;
        int          cycles;
        logic [31:0] held_addr;

        ar_delay  = {$random(seed)} % 4;
        r_delay   = {$random(seed)} % 4;
        held_addr = araddr;
        repeat (ar_delay) begin
            @(negedge clk);
            compare(arvalid, 1'b1, "arvalid before arready");
            compare(araddr, held_addr, "araddr before arready");
        end
        arready = 1'b1;
        addr    = araddr;
        cycles  = 0;
        while (arvalid) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("address handshake");
            end
        end
        arready = 1'b0;
        compare(rready, 1'b1, "rready after address handshake");
        repeat (r_delay) begin
            @(negedge clk);
            compare(rready, 1'b1, "rready while rvalid is low");
        end
        rvalid = 1'b1;
        rdata  = {addr << 1, ~addr};
        rresp  = resp;
        rlast  = 1'b1;
        rid    = `ICACHE_READ_ID;
        cycles = 0;
        while (rready) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("read beat");
            end
        end
        rvalid = 1'b0;
        rlast  = 1'b0;
    endtask

    // ==================================================
    // stimulus table

    task automatic add_step(input logic [31:0] step_pc, input logic step_stall,
                            input logic step_flush, input logic [1:0] step_resp);
        stim_t s;

        s.pc    = step_pc;
        s.stall = step_stall;
        s.flush = step_flush;
        s.resp  = step_resp;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] rand_bits;

        // cold misses, both word selects
        add_step(32'h1000_0080, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h2000_0104, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h1000_0080, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h1000_0084, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h2000_0100, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        // three tags in set 0x40
        add_step(32'h0001_0200, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0002_0204, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0001_0204, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0002_0200, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0003_0200, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0002_0204, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0001_0200, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h0003_0204, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        // slave error, then a good refill
        add_step(32'h3000_0300, 1'b0, 1'b0, 2'b10);
        add_step(32'h3000_0304, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h4000_0300, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        // stall blocks the miss and masks the flush
        add_step(32'h5000_0400, 1'b1, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h5000_0400, 1'b1, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h5000_0400, 1'b1, 1'b1, `ICACHE_RESP_OKAY);
        add_step(32'h1000_0084, 1'b0, 1'b1, `ICACHE_RESP_OKAY);
        add_step(32'h1000_0084, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        add_step(32'h5000_0400, 1'b0, 1'b0, `ICACHE_RESP_OKAY);
        // few tags fighting over set 0x50
        for (int i = 0; i < 12; i++) begin
            rand_bits = $random(seed);
            add_step({{19'd0, rand_bits[1:0]} + 21'd8, 8'h50, rand_bits[2], 2'b00},
                     1'b0, 1'b0, `ICACHE_RESP_OKAY);
        end
    endtask

    // ==================================================
    // one table entry, starting and ending at a falling edge

    task automatic apply_step(input stim_t s);
        logic [20:0] tag;
        logic [7:0]  index;
        logic        word_sel;
        logic [31:0] aligned;
        logic [31:0] bus_addr;
        logic        hit;
        logic        way;
        logic [63:0] line;

        tag      = s.pc[31:11];
        index    = s.pc[10:3];
        word_sel = s.pc[2];
        aligned  = {s.pc[31:3], 3'b000};
        pc       = s.pc;
        stall    = s.stall;
        flush    = s.flush;
        @(negedge clk);
        if (s.stall) begin
            compare(arvalid, 1'b0, "arvalid under stall");
            compare(inst_valid, last_valid, "inst_valid under stall");
            compare(inst, last_inst, "inst under stall");
        end else if (s.flush) begin
            compare(arvalid, 1'b0, "arvalid after flush");
            compare(inst_valid, 1'b1, "inst_valid after flush");
            compare(inst, `ICACHE_NOP, "inst after flush");
            last_inst  = `ICACHE_NOP;
            last_valid = 1'b1;
        end else begin
            hit = 1'b0;
            way = 1'b0;
            if (model_valid[0][index] && model_tag[0][index] == tag) begin
                hit = 1'b1;
            end else if (model_valid[1][index] && model_tag[1][index] == tag) begin
                hit = 1'b1;
                way = 1'b1;
            end
            if (hit) begin
                compare(arvalid, 1'b0, "arvalid on hit");
                compare(inst_valid, 1'b1, "inst_valid on hit");
                line = model_line[way][index];
            end else begin
                compare(arvalid, 1'b1, "arvalid on miss");
                compare(inst_valid, 1'b0, "inst_valid during miss");
                compare(araddr, aligned, "araddr on miss");
                // invalid way first, else flip the set's victim bit
                if (!model_valid[0][index]) begin
                    way = 1'b0;
                end else if (!model_valid[1][index]) begin
                    way = 1'b1;
                end else begin
                    way = !model_victim[index];
                end
                model_victim[index] = way;
                serve_read(s.resp, bus_addr);
                compare(bus_addr, aligned, "address taken by the bus");
                line = {aligned << 1, ~aligned};
                model_tag[way][index]   = tag;
                model_valid[way][index] = 1'b1;
                model_line[way][index]  = line;
                model_error = (s.resp != `ICACHE_RESP_OKAY);
                compare(inst_valid, 1'b1, "inst_valid after refill");
            end
            last_inst  = word_sel ? line[63:32] : line[31:0];
            last_valid = 1'b1;
            compare(inst, last_inst, "delivered instruction");
        end
        compare(error, model_error, "error flag");
    endtask

    // ==================================================
    // main sequence

    initial begin
        seed     = 97;
        failures = 0;
        rst      = 1'b1;
        pc       = '0;
        flush    = 1'b0;
        stall    = 1'b1;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rresp    = `ICACHE_RESP_OKAY;
        rdata    = '0;
        rlast    = 1'b0;
        rid      = `ICACHE_READ_ID;
        for (int s = 0; s < 256; s++) begin
            model_victim[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                model_tag[w][s]   = '0;
                model_valid[w][s] = 1'b0;
                model_line[w][s]  = '0;
            end
        end
        model_error = 1'b0;
        build_table();

        repeat (8) @(negedge clk);
        rst = 1'b0;
        compare(arvalid, 1'b0, "arvalid after reset");
        compare(rready, 1'b0, "rready after reset");
        compare(error, 1'b0, "error after reset");
        compare(inst_valid, 1'b1, "inst_valid after reset");
        compare(inst, `ICACHE_NOP, "inst after reset");
        last_inst  = `ICACHE_NOP;
        last_valid = 1'b1;

        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        failures += i_icache_top.i_handshake_checks.fail_count;

        if (failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/icache_top_assertions.sv
// read channel checks
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_top_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      arvalid,
    input logic                      arready,
    input logic [`ICACHE_ADDR_W-1:0] araddr,
    input logic                      rready
);

    // failed checks so far
    int unsigned fail_count = 0;

    // request holds until accepted
    property ar_held;
        @(posedge clk) disable iff (rst)
            (arvalid && !arready) |=> (arvalid && $stable(araddr));
    endproperty

    // address and data phases never overlap
    property no_phase_overlap;
        @(posedge clk) disable iff (rst)
            !(arvalid && rready);
    endproperty

    property ar_low_after_reset;
        @(posedge clk) rst |=> !arvalid;
    endproperty

    assert property (ar_held)
        else begin
            fail_count++;
            $error("arvalid dropped or araddr moved before arready");
        end
    assert property (no_phase_overlap)
        else begin
            fail_count++;
            $error("rready high while arvalid is high");
        end
    assert property (ar_low_after_reset)
        else begin
            fail_count++;
            $error("arvalid high in the cycle after reset");
        end

endmodule

bind icache_top icache_top_assertions i_handshake_checks (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rready  (rready)
);

`default_nettype wire

//--- verilog/icache_top.sv
// instruction cache top level
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ICACHE_ADDR_W-1:0] pc,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      arready,
    output logic                      arvalid,
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      rready,
    input  logic                      rvalid,
    input  logic [1:0]                rresp,
    input  logic [`ICACHE_LINE_W-1:0] rdata,
    input  logic                      rlast,
    input  logic [3:0]                rid,
    output logic [`ICACHE_INST_W-1:0] inst,
    output logic                      inst_valid,
    output logic                      error
);

    import icache_pkg::*;

    fetch_addr_t               fetch_addr;
    logic                      lookup_en;
    logic                      miss_start;
    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    logic [`ICACHE_INST_W-1:0] hit_word;

    assign fetch_addr = pc;

    // refill write shared by both stores
    icache_refill_if #(
        .TAG_W   (`ICACHE_TAG_W),
        .INDEX_W (`ICACHE_INDEX_W),
        .LINE_W  (`ICACHE_LINE_W)
    ) refill_bus ();

    // ==================================================
    // arrays

    icache_tag_store i_tag_store (
        .clk        (clk),
        .rst        (rst),
        .lookup_en  (lookup_en),
        .addr       (fetch_addr),
        .miss_start (miss_start),
        .refill     (refill_bus.store),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_store i_data_store (
        .clk       (clk),
        .lookup_en (lookup_en),
        .addr      (fetch_addr),
        .hit_way   (hit_way),
        .refill    (refill_bus.store),
        .word      (hit_word)
    );

    // ==================================================
    // sequencer and bus

    icache_miss_ctrl i_miss_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pc         (fetch_addr),
        .flush      (flush),
        .stall      (stall),
        .hit        (hit),
        .victim_way (victim_way),
        .hit_word   (hit_word),
        .arready    (arready),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rresp      (rresp),
        .rdata      (rdata),
        .rid        (rid),
        .lookup_en  (lookup_en),
        .miss_start (miss_start),
        .refill     (refill_bus.sequencer),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error)
    );

endmodule

`default_nettype wire

//--- verilog/icache_miss_ctrl.sv
// instruction cache miss sequencer
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_miss_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  icache_pkg::fetch_addr_t   pc,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      hit,
    input  logic                      victim_way,
    input  logic [`ICACHE_INST_W-1:0] hit_word,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic                      rlast,
    input  logic [1:0]                rresp,
    input  logic [`ICACHE_LINE_W-1:0] rdata,
    input  logic [3:0]                rid,
    output logic                      lookup_en,
    output logic                      miss_start,
    icache_refill_if.sequencer        refill,
    output logic                      arvalid,
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      rready,
    output logic [`ICACHE_INST_W-1:0] inst,
    output logic                      inst_valid,
    output logic                      error
);

    import icache_pkg::*;

    seq_state_t   state;
    seq_state_t   state_next;

    fetch_addr_t  miss_addr;
    logic         miss_way;
    refill_beat_u beat;

    logic                      flush_now;
    logic                      beat_taken;
    logic                      line_done;
    logic                      hit_sel;
    logic [`ICACHE_INST_W-1:0] inst_reg;

    // flush is ignored while the pipeline stalls
    assign flush_now  = flush && !stall;

    assign lookup_en  = (state == seq_idle) && !stall;
    assign miss_start = lookup_en && !hit && !flush;

    assign beat_taken = rvalid && rready;
    assign line_done  = beat_taken && rlast;

    // ==================================================
    // sequencer

    always_comb begin
        state_next = state;
        case (state)
            seq_idle: begin
                if (miss_start) begin
                    state_next = seq_request;
                end
            end
            seq_request: begin
                if (arvalid && arready) begin
                    state_next = seq_wait;
                end
            end
            seq_wait: begin
                if (line_done) begin
                    state_next = seq_idle;
                end
            end
            default: state_next = seq_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_now) begin
            state <= seq_idle;
        end else begin
            state <= state_next;
        end
    end

    // missed address and chosen way
    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_addr <= pc;
            miss_way  <= victim_way;
        end
    end

    // ==================================================
    // read channel

    assign arvalid = (state == seq_request);
    assign araddr  = {miss_addr.tag, miss_addr.index, {`ICACHE_OFFSET_W{1'b0}}};
    assign rready  = (state == seq_wait);

    assign beat = rdata;

    // refill write lands on the edge that takes the beat
    assign refill.we    = line_done && !flush_now;
    assign refill.index = miss_addr.index;
    assign refill.way   = miss_way;
    assign refill.tag   = miss_addr.tag;
    assign refill.line  = beat.line;

    // ==================================================
    // delivered instruction

    always_ff @(posedge clk) begin
        if (rst || flush_now) begin
            inst_reg   <= `ICACHE_NOP;
            hit_sel    <= 1'b0;
            inst_valid <= 1'b1;
        end else if (line_done) begin
            inst_reg   <= beat.inst[miss_addr.word_sel];
            hit_sel    <= 1'b0;
            inst_valid <= 1'b1;
        end else if (miss_start) begin
            hit_sel    <= 1'b0;
            inst_valid <= 1'b0;
        end else if (lookup_en && hit) begin
            hit_sel    <= 1'b1;
        end
    end

    assign inst = hit_sel ? hit_word : inst_reg;

    // response check, once per beat
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (beat_taken) begin
            error <= (rresp != `ICACHE_RESP_OKAY) || (rid != `ICACHE_READ_ID);
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_data_store.sv
// instruction cache data store
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_data_store (
    input  logic                      clk,
    input  logic                      lookup_en,
    input  icache_pkg::fetch_addr_t   addr,
    input  logic                      hit_way,
    icache_refill_if.store            refill,
    output logic [`ICACHE_INST_W-1:0] word
);

    import icache_pkg::*;

    // two ways of 64-bit lines
    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_WAYS][`ICACHE_SETS];

    refill_beat_u rd_line;
    logic         rd_sel;

    // ==================================================
    // line write from the sequencer

    always_ff @(posedge clk) begin
        if (refill.we) begin
            line_mem[refill.way][refill.index] <= refill.line;
        end
    end

    // ==================================================
    // synchronous read

    // only idle lookups read, refill only writes in wait
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_line <= line_mem[hit_way][addr.index];
            rd_sel  <= addr.word_sel;
        end
    end

    // pick the instruction half
    assign word = rd_line.inst[rd_sel];

endmodule

`default_nettype wire

//--- verilog/icache_tag_store.sv
// instruction cache tag store
`timescale 1ns/10ps
`default_nettype none

`include "icache_defines.svh"

module icache_tag_store (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lookup_en,
    input  icache_pkg::fetch_addr_t addr,
    input  logic                    miss_start,
    icache_refill_if.store          refill,
    output logic                    hit,
    output logic                    hit_way,
    output logic                    victim_way
);

    import icache_pkg::*;

    logic [`ICACHE_TAG_W-1:0] tag_mem   [`ICACHE_WAYS][`ICACHE_SETS];
    logic                     valid_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic                     victim_mem [`ICACHE_SETS];

    logic [`ICACHE_WAYS-1:0]  way_hit;
    logic                     next_victim;

    // ==================================================
    // lookup

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = valid_mem[w][addr.index] && (tag_mem[w][addr.index] == addr.tag);
        end
    end

    assign hit     = lookup_en && (|way_hit);
    // way 0 wins if both ever match
    assign hit_way = !way_hit[0] && way_hit[1];

    // ==================================================
    // replacement

    always_comb begin
        if (!valid_mem[0][addr.index]) begin
            next_victim = 1'b0;
        end else if (!valid_mem[1][addr.index]) begin
            next_victim = 1'b1;
        end else begin
            next_victim = !victim_mem[addr.index];
        end
    end

    // sequencer latches this on miss_start
    assign victim_way = next_victim;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                victim_mem[s] <= 1'b0;
            end
        end else if (miss_start) begin
            victim_mem[addr.index] <= next_victim;
        end
    end

    // ==================================================
    // refill of tag and valid

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    tag_mem[w][s]   <= '0;
                    valid_mem[w][s] <= 1'b0;
                end
            end
        end else if (refill.we) begin
            tag_mem[refill.way][refill.index]   <= refill.tag;
            valid_mem[refill.way][refill.index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_refill_if.sv
// refill write channel
`timescale 1ns/10ps
`default_nettype none

interface icache_refill_if #(
    parameter int TAG_W   = 21,
    parameter int INDEX_W = 8,
    parameter int LINE_W  = 64
);

    // one line write per clock edge with we high
    logic               we;
    logic [INDEX_W-1:0] index;
    logic               way;
    logic [TAG_W-1:0]   tag;
    logic [LINE_W-1:0]  line;

    modport sequencer (
        output we,
        output index,
        output way,
        output tag,
        output line
    );

    // tag store and data store both listen
    modport store (
        input we,
        input index,
        input way,
        input tag,
        input line
    );

endinterface

`default_nettype wire

//--- verilog/icache_pkg.sv
// instruction cache types
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // fetch address split for the 2-way 256-set cache
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic                        word_sel;
        logic [`ICACHE_OFFSET_W-2:0] byte_off;
    } fetch_addr_t;

    // one bus beat
    // stored whole, or split into two instructions
    typedef union packed {
        logic [`ICACHE_LINE_W-1:0] line;
        // low word first
        logic [`ICACHE_LINE_W/`ICACHE_INST_W-1:0][`ICACHE_INST_W-1:0] inst;
    } refill_beat_u;

    // miss sequencer
    typedef enum logic [1:0] {
        seq_idle    = `ICACHE_SEQ_IDLE,
        seq_request = `ICACHE_SEQ_REQUEST,
        seq_wait    = `ICACHE_SEQ_WAIT
    } seq_state_t;

endpackage

`default_nettype wire

//--- verilog/icache_defines.svh
// instruction cache parameters
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ==================================================
// widths
`define ICACHE_ADDR_W       32
`define ICACHE_INST_W       32
`define ICACHE_LINE_W       64

// ==================================================
// geometry, 4 KB in 2 ways of 256 sets
`define ICACHE_INDEX_W      8
`define ICACHE_OFFSET_W     3
`define ICACHE_TAG_W        21
`define ICACHE_SETS         256
`define ICACHE_WAYS         2

// miss sequencer state codes
`define ICACHE_SEQ_IDLE     2'd0
`define ICACHE_SEQ_REQUEST  2'd1
`define ICACHE_SEQ_WAIT     2'd2

// ==================================================
// bus and pipeline constants
`define ICACHE_NOP          32'h0000_0013
`define ICACHE_RESP_OKAY    2'b00
`define ICACHE_READ_ID      4'h0

`endif
